// File: src/mul_settings.svh
// Width settings for the 32x32 multiplier, included by every file that sizes a bus
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// ------------------------------------------------------------
// Operand and product sizes
// ------------------------------------------------------------

// Width of each operand a and b
`define MUL_WIDTH 32

// Bit position where b is cut into a low and a high half
`define MUL_SPLIT 16

// Full product, never truncated
`define MUL_PROD_WIDTH (2 * `MUL_WIDTH)

`endif

// File: src/mul_op_pkg.sv
// Operation types for the multiplier: opcodes, operand type and operand-a extension
`default_nettype none

`include "mul_settings.svh"

package mul_op_pkg;

   // ------------------------------------------------------------
   // Opcodes
   // ------------------------------------------------------------

   // First letter is the signedness of a, second the signedness of b
   typedef enum logic [1:0] {
      MUL_UU = 2'b00,
      MUL_SS = 2'b01,
      MUL_SU = 2'b10,
      MUL_US = 2'b11
   } mul_op_e;

   // Raw operand as it arrives on the input port
   typedef logic [`MUL_WIDTH-1:0] mul_operand_t;

   // Extend a by one bit so that both rows see a signed multiplicand
   // Sign extension only when the opcode treats a as signed
   function automatic logic signed [`MUL_WIDTH:0] mul_ext_a(input mul_operand_t a,
                                                            input mul_op_e op);
      logic a_signed;
      a_signed = (op == MUL_SS) || (op == MUL_SU);
      return $signed({a_signed & a[`MUL_WIDTH-1], a});
   endfunction

endpackage

`default_nettype wire

// File: src/mul_result_pkg.sv
// Result types for the multiplier: partial products of the two rows and the full product
`default_nettype none

`include "mul_settings.svh"

package mul_result_pkg;

   // ------------------------------------------------------------
   // Partial and full products
   // ------------------------------------------------------------

   // Extended a (width + 1) times an extended half of b (split + 1)
   localparam int MUL_PARTIAL_WIDTH = (`MUL_WIDTH + 1) + (`MUL_SPLIT + 1);

   // Always signed, the extension bits carry the operand signedness
   typedef logic signed [MUL_PARTIAL_WIDTH-1:0] mul_partial_t;

   // Full-width product handed to the output port
   typedef logic [`MUL_PROD_WIDTH-1:0] mul_product_t;

endpackage

`default_nettype wire

// File: src/mul_pipe_ctrl.sv
// Two-stage occupancy tracking and stall logic for the multiplier pipeline
`default_nettype none
`timescale 1ns/1ps

module mul_pipe_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic in_valid,
   input  logic out_ready,
   output logic in_ready,
   output logic load_s1,
   output logic load_s2,
   output logic out_valid
);

   // Stage holds a valid item
   logic s1_full;
   logic s2_full;

   // ------------------------------------------------------------
   // Advance conditions
   // ------------------------------------------------------------

   // Stage 2 takes the item when it is free or being drained this edge
   assign load_s2 = s1_full && (!s2_full || out_ready);

   // Stage 1 can take a new pair when empty or moving on
   assign in_ready = !s1_full || load_s2;
   assign load_s1  = in_ready && in_valid;

   // Stage 2 flag is the product-valid seen outside
   assign out_valid = s2_full;

   // ------------------------------------------------------------
   // Occupancy flags
   // ------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_full <= 1'b0;
         s2_full <= 1'b0;
      end else begin
         // New item wins over the one leaving
         if (load_s1) begin
            s1_full <= 1'b1;
         end else if (load_s2) begin
            s1_full <= 1'b0;
         end
         // Drained with nothing behind it
         if (load_s2) begin
            s2_full <= 1'b1;
         end else if (out_ready) begin
            s2_full <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/mul_row_lo.sv
// First-stage row multiplying the extended a by the low half of b
`default_nettype none
`timescale 1ns/1ps

`include "mul_settings.svh"

module mul_row_lo
   import mul_op_pkg::*;
   import mul_result_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         load_s1,
   input  mul_operand_t a,
   input  mul_operand_t b,
   input  mul_op_e      op_sel,
   output mul_partial_t partial_lo
);

   // Multiplicand and low multiplier, both signed for the product
   logic signed [`MUL_WIDTH:0] a_ext;
   logic signed [`MUL_SPLIT:0] b_lo_ext;
   mul_partial_t               prod_lo;

   // ------------------------------------------------------------
   // Partial product
   // ------------------------------------------------------------

   assign a_ext    = mul_ext_a(a, op_sel);
   // Low half carries no sign for any opcode
   assign b_lo_ext = $signed({1'b0, b[`MUL_SPLIT-1:0]});
   assign prod_lo  = a_ext * b_lo_ext;

   // Captured on the acceptance edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         partial_lo <= '0;
      end else if (load_s1) begin
         partial_lo <= prod_lo;
      end
   end

endmodule

`default_nettype wire

// File: src/mul_row_hi.sv
// First-stage row multiplying the extended a by the high half of b
`default_nettype none
`timescale 1ns/1ps

`include "mul_settings.svh"

module mul_row_hi
   import mul_op_pkg::*;
   import mul_result_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         load_s1,
   input  mul_operand_t a,
   input  mul_operand_t b,
   input  mul_op_e      op_sel,
   output mul_partial_t partial_hi
);

   // High half of b is the upper bits above the split point
   localparam int HI_W = `MUL_WIDTH - `MUL_SPLIT;

   logic                       b_signed;
   logic signed [`MUL_WIDTH:0] a_ext;
   logic signed [HI_W:0]       b_hi_ext;
   mul_partial_t               prod_hi;

   // ------------------------------------------------------------
   // Partial product
   // ------------------------------------------------------------

   // b is signed for SS and US, its sign sits in the high half
   assign b_signed = (op_sel == MUL_SS) || (op_sel == MUL_US);

   assign a_ext    = mul_ext_a(a, op_sel);
   assign b_hi_ext = $signed({b_signed & b[`MUL_WIDTH-1], b[`MUL_WIDTH-1:`MUL_SPLIT]});
   assign prod_hi  = a_ext * b_hi_ext;

   // Same edge as the low row
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         partial_hi <= '0;
      end else if (load_s1) begin
         partial_hi <= prod_hi;
      end
   end

endmodule

`default_nettype wire

// File: src/mul_combine.sv
// Second stage that shifts and adds the two partial products into the final result
`default_nettype none
`timescale 1ns/1ps

`include "mul_settings.svh"

module mul_combine
   import mul_result_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         load_s2,
   input  mul_partial_t partial_lo,
   input  mul_partial_t partial_hi,
   output mul_product_t result
);

   // Partials widened to product size, sign kept
   logic signed [`MUL_PROD_WIDTH-1:0] lo_wide;
   logic signed [`MUL_PROD_WIDTH-1:0] hi_wide;
   mul_product_t                      sum;

   // ------------------------------------------------------------
   // Shift and add
   // ------------------------------------------------------------

   // Signed source, so widening sign-extends
   assign lo_wide = partial_lo;
   assign hi_wide = partial_hi;

   // High row weighs 2^split, wrap beyond the product width is exact
   assign sum = mul_product_t'((hi_wide <<< `MUL_SPLIT) + lo_wide);

   // Output register, held while the sink stalls
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         result <= '0;
      end else if (load_s2) begin
         result <= sum;
      end
   end

endmodule

`default_nettype wire

// File: src/multiplier_32x32.sv
// Top level of the pipelined 32x32 multiplier with valid/ready ports on both sides
`default_nettype none
`timescale 1ns/1ps

module multiplier_32x32
   import mul_op_pkg::*;
   import mul_result_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  mul_operand_t a,
   input  mul_operand_t b,
   input  mul_op_e      op_sel,
   input  logic         in_valid,
   output logic         in_ready,
   output logic         out_valid,
   input  logic         out_ready,
   output mul_product_t result
);

   // Stage enables from the controller
   logic load_s1;
   logic load_s2;

   // Stage-1 registers feeding the combiner
   mul_partial_t partial_lo;
   mul_partial_t partial_hi;

   // ------------------------------------------------------------
   // Pipeline control
   // ------------------------------------------------------------

   mul_pipe_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .out_ready (out_ready),
      .in_ready  (in_ready),
      .load_s1   (load_s1),
      .load_s2   (load_s2),
      .out_valid (out_valid)
   );

   // ------------------------------------------------------------
   // Stage 1, one row per half of b
   // ------------------------------------------------------------

   mul_row_lo u_row_lo (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_s1    (load_s1),
      .a          (a),
      .b          (b),
      .op_sel     (op_sel),
      .partial_lo (partial_lo)
   );

   mul_row_hi u_row_hi (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_s1    (load_s1),
      .a          (a),
      .b          (b),
      .op_sel     (op_sel),
      .partial_hi (partial_hi)
   );

   // Stage 2, drives the result port directly
   mul_combine u_combine (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_s2    (load_s2),
      .partial_lo (partial_lo),
      .partial_hi (partial_hi),
      .result     (result)
   );

endmodule

`default_nettype wire

// File: verif/mul_props.sv
// Concurrent checks on the multiplier stream ports, attached to the top level by bind
`timescale 1ns/1ps
`default_nettype none

module mul_props
   import mul_op_pkg::*;
   import mul_result_pkg::*;
(
   input logic         clk,
   input logic         rst_n,
   input mul_op_e      op_sel,
   input logic         in_valid,
   input logic         in_ready,
   input logic         out_valid,
   input logic         out_ready,
   input mul_product_t result
);

   // Failed assertions, read by the testbench at the end of the run
   int fail_count = 0;

   // ------------------------------------------------------------
   // Stream properties
   // ------------------------------------------------------------

   // Stalled output keeps its value
   result_held_a : assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> $stable(result))
      else begin
         fail_count++;
         $error("result changed while out_valid was high and out_ready low");
      end

   reset_idle_a : assert property (@(posedge clk) !rst_n |=> !out_valid)
      else begin
         fail_count++;
         $error("out_valid high in the cycle after reset");
      end

   // Stage 2 empty means room in stage 1
   ready_when_empty_a : assert property (@(posedge clk) disable iff (!rst_n)
      !out_valid |-> in_ready)
      else begin
         fail_count++;
         $error("in_ready low while out_valid was low");
      end

   op_known_a : assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> !$isunknown(op_sel))
      else begin
         fail_count++;
         $error("op_sel unknown while in_valid was high");
      end

endmodule

bind multiplier_32x32 mul_props props0 (
   .clk       (clk),
   .rst_n     (rst_n),
   .op_sel    (op_sel),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .result    (result)
);

`default_nettype wire

// File: verif/mul_tb.sv
// Self-checking testbench for the 32x32 multiplier, run as the simulation top from build.f
`timescale 1ns/1ps
`include "mul_settings.svh"
`default_nettype none

module mul_tb
   import mul_op_pkg::*;
   import mul_result_pkg::*;
();

   // Cycle limits for the wait loops
   localparam int HANDSHAKE_LIMIT = 200;
   localparam int DRAIN_LIMIT     = 2000;

   // How out_ready behaves
   localparam int READY_HIGH   = 0;
   localparam int READY_RANDOM = 1;
   localparam int READY_STALL  = 2;

   logic         clk;
   logic         rst_n;
   mul_operand_t a;
   mul_operand_t b;
   mul_op_e      op_sel;
   logic         in_valid;
   logic         in_ready;
   logic         out_valid;
   logic         out_ready;
   mul_product_t result;

   // Scoreboard, one entry per accepted pair
   mul_product_t exp_q[$];
   int           accept_edge_q[$];
   int           edge_count = 0;
   logic         latency_on;
   int           ready_mode;
   logic [31:0]  lcg_state;
   mul_operand_t corners [0:4];

   multiplier_32x32 dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .a         (a),
      .b         (b),
      .op_sel    (op_sel),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .result    (result)
   );

   // ------------------------------------------------------------
   // Clock and edge counter
   // ------------------------------------------------------------

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk) begin
      edge_count <= edge_count + 1;
   end

   // ------------------------------------------------------------
   // Random numbers and reference model
   // ------------------------------------------------------------

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Upper LCG bits only, the low ones repeat quickly
   function automatic mul_operand_t random_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_random();
      lo = next_random();
      return {hi[31:16], lo[31:16]};
   endfunction

   // Opcodes with at least one signed operand
   function automatic mul_op_e signed_op();
      logic [31:0] r;
      r = next_random();
      case (r[31:30])
         2'd1:    return MUL_SU;
         2'd2:    return MUL_US;
         default: return MUL_SS;
      endcase
   endfunction

   // Both operands widened to product size, then one plain multiply
   function automatic mul_product_t expected_product(input mul_operand_t x,
                                                     input mul_operand_t y,
                                                     input mul_op_e op);
      logic                       x_signed;
      logic                       y_signed;
      logic [`MUL_PROD_WIDTH-1:0] x_wide;
      logic [`MUL_PROD_WIDTH-1:0] y_wide;
      x_signed = (op == MUL_SS) || (op == MUL_SU);
      y_signed = (op == MUL_SS) || (op == MUL_US);
      x_wide   = {{`MUL_WIDTH{x_signed & x[`MUL_WIDTH-1]}}, x};
      y_wide   = {{`MUL_WIDTH{y_signed & y[`MUL_WIDTH-1]}}, y};
      return x_wide * y_wide;
   endfunction

   // ------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_product(input string name, input mul_product_t got,
                                input mul_product_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // Edges between acceptance and delivery
   task automatic check_latency(input string name, input int got, input int exp);
      if (got != exp) begin
         stop_on_error($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // ------------------------------------------------------------
   // Stimulus, always 1 ns after the rising edge
   // ------------------------------------------------------------

   task automatic advance_cycle();
      logic [31:0] r;
      @(posedge clk);
      #1;
      r = next_random();
      case (ready_mode)
         READY_HIGH:   out_ready = 1'b1;
         READY_RANDOM: out_ready = r[31];
         default: begin
            // Drops often, recovers rarely, so stalls run long
            if (out_ready && r[31:30] == 2'd0) begin
               out_ready = 1'b0;
            end else if (!out_ready && r[31:28] == 4'd0) begin
               out_ready = 1'b1;
            end
         end
      endcase
   endtask

   // Holds the pair until the DUT takes it
   task automatic send_item(input mul_operand_t x, input mul_operand_t y, input mul_op_e op);
      int   waited;
      logic taken;
      a        = x;
      b        = y;
      op_sel   = op;
      in_valid = 1'b1;
      taken    = 1'b0;
      waited   = 0;
      while (!taken) begin
         if (waited >= HANDSHAKE_LIMIT) begin
            stop_on_error("Timeout: in_ready never accepted the operand pair");
         end
         @(negedge clk);
         taken = in_ready;
         advance_cycle();
         waited++;
      end
   endtask

   task automatic idle_cycles(input int n);
      in_valid = 1'b0;
      repeat (n) advance_cycle();
   endtask

   // Occasional bubble in in_valid
   task automatic random_gap();
      logic [31:0] r;
      r = next_random();
      if (r[31:30] == 2'd0) begin
         idle_cycles(int'(r[29:28]) + 1);
      end
   endtask

   task automatic wait_drain();
      int waited;
      in_valid = 1'b0;
      waited   = 0;
      while (exp_q.size() != 0) begin
         if (waited >= DRAIN_LIMIT) begin
            stop_on_error("Timeout: outstanding products never came out");
         end
         advance_cycle();
         waited++;
      end
   endtask

   // ------------------------------------------------------------
   // Monitor, sampled at the falling edge
   // ------------------------------------------------------------

   always @(negedge clk) begin
      mul_product_t expected;
      int           accept_edge;
      if (rst_n === 1'b1) begin
         // Only with both stages full may in_ready drop
         check_flag("in_ready", in_ready, (exp_q.size() < 2) || out_ready);
         if (exp_q.size() == 0) begin
            check_flag("out_valid", out_valid, 1'b0);
         end
         if (out_valid === 1'b1 && out_ready) begin
            expected    = exp_q.pop_front();
            accept_edge = accept_edge_q.pop_front();
            check_product("result", result, expected);
            if (latency_on) begin
               check_latency("latency", edge_count + 1 - accept_edge, 2);
            end
         end
         if (in_valid && in_ready === 1'b1) begin
            exp_q.push_back(expected_product(a, b, op_sel));
            accept_edge_q.push_back(edge_count + 1);
         end
      end
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------

   initial begin
      int           i;
      int           j;
      int           k;
      mul_operand_t x;
      mul_operand_t y;
      corners[0] = 32'h0000_0000;
      corners[1] = 32'h0000_0001;
      corners[2] = 32'hFFFF_FFFF;
      corners[3] = 32'h8000_0000;
      corners[4] = 32'h7FFF_FFFF;
      lcg_state  = 32'h209;
      rst_n      = 1'b0;
      a          = '0;
      b          = '0;
      op_sel     = MUL_UU;
      in_valid   = 1'b0;
      out_ready  = 1'b1;
      latency_on = 1'b0;
      ready_mode = READY_HIGH;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Idle state straight out of reset
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b0);
      check_flag("in_ready", in_ready, 1'b1);
      advance_cycle();

      // Unsigned products under random back-pressure
      ready_mode = READY_RANDOM;
      for (i = 0; i < 200; i++) begin
         x = random_word();
         y = random_word();
         send_item(x, y, MUL_UU);
         random_gap();
      end

      // Mixed signedness
      for (i = 0; i < 300; i++) begin
         x = random_word();
         y = random_word();
         send_item(x, y, signed_op());
         random_gap();
      end

      // Every corner pair under every opcode
      for (i = 0; i < 5; i++) begin
         for (j = 0; j < 5; j++) begin
            for (k = 0; k < 4; k++) begin
               send_item(corners[i], corners[j], mul_op_e'(k));
            end
         end
      end

      // Long output stalls
      ready_mode = READY_STALL;
      for (i = 0; i < 200; i++) begin
         x = random_word();
         y = random_word();
         k = int'(next_random() >> 30);
         send_item(x, y, mul_op_e'(k));
         random_gap();
      end

      // Back-to-back with the sink always ready, fixed two-edge latency
      ready_mode = READY_HIGH;
      out_ready  = 1'b1;
      wait_drain();
      latency_on = 1'b1;
      for (i = 0; i < 64; i++) begin
         x = random_word();
         y = random_word();
         k = int'(next_random() >> 30);
         send_item(x, y, mul_op_e'(k));
      end
      wait_drain();
      latency_on = 1'b0;

      if (exp_q.size() == 0 && dut0.props0.fail_count == 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         stop_on_error($sformatf("%0d accepted items never came out and %0d properties failed",
                                 exp_q.size(), dut0.props0.fail_count));
      end
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
src/mul_op_pkg.sv
src/mul_result_pkg.sv
src/mul_pipe_ctrl.sv
src/mul_row_lo.sv
src/mul_row_hi.sv
src/mul_combine.sv
src/multiplier_32x32.sv
verif/mul_props.sv
verif/mul_tb.sv

// File: Bender.yml
package:
  name: multiplier_32x32

export_include_dirs:
  - src

sources:
  # Synthesizable RTL, packages first
  - include_dirs:
      - src
    files:
      - src/mul_op_pkg.sv
      - src/mul_result_pkg.sv
      - src/mul_pipe_ctrl.sv
      - src/mul_row_lo.sv
      - src/mul_row_hi.sv
      - src/mul_combine.sv
      - src/multiplier_32x32.sv

  # Bound properties and testbench top mul_tb
  - target: test
    include_dirs:
      - src
    files:
      - verif/mul_props.sv
      - verif/mul_tb.sv
